// File: common/csr_unit_settings.svh
// Build-time sizing for the CSR execution path.
// XLEN must be at least 12, since operand_b carries the CSR address in
// its low bits. The CSR window is CSR_BASE up to CSR_BASE + CSR_COUNT - 1
// and must not wrap past 12'hfff.
`ifndef CSR_UNIT_SETTINGS_SVH
`define CSR_UNIT_SETTINGS_SVH

// data width of every CSR and operand
`define XLEN 32

// first implemented CSR address
`define CSR_BASE 12'h340

// number of implemented CSRs, contiguous from CSR_BASE
`define CSR_COUNT 4

// instruction queue entries
`define QUEUE_DEPTH 4

`endif

// File: common/csr_unit_pkg.sv
// Shared types for the CSR execution path.
// Widths come from the settings header. The enum encoding matches the
// 2-bit op field that the instruction source drives.
`default_nettype none

`include "csr_unit_settings.svh"

package csr_unit_pkg;

  // csr operation, 2 bits on the wire
  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

  // instruction as it arrives from outside and sits in the queue
  typedef struct packed {
    csr_op_e           op;
    logic [11:0]       addr;
    logic [`XLEN-1:0]  operand;
  } csr_instr_t;

  // operand carrier from issue to the csr buffer
  // operand_a is the write operand
  // operand_b holds the csr address in bits 11:0, upper bits zero
  typedef struct packed {
    csr_op_e           op;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  operand_b;
  } fu_data_t;

  // old csr value plus illegal-address flag
  typedef struct packed {
    logic [`XLEN-1:0]  rdata;
    logic              illegal;
  } csr_result_t;

endpackage

`default_nettype wire

// File: source/csr_buffer.sv
// One-entry holding register for the CSR address of the issued
// instruction, kept until the commit side consumes it.
// csr_ready_o does not look at csr_valid_i, so the issuer may drive
// csr_valid_i from csr_ready_o without a combinational loop.
`default_nettype none

`include "csr_unit_settings.svh"

module csr_buffer
  import csr_unit_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              flush_i,
  input  wire fu_data_t          fu_data_i,
  input  wire logic              csr_valid_i,
  output      logic              csr_ready_o,
  output      logic [`XLEN-1:0]  csr_result_o,
  input  wire logic              csr_commit_i,
  output      logic [11:0]       csr_addr_o
);

  typedef struct packed {
    logic [11:0] addr;
    logic        valid;
  } csr_entry_t;

  csr_entry_t entry_q;
  csr_entry_t entry_n;

  // write operand goes straight back to the commit side
  assign csr_result_o = fu_data_i.operand_a;
  assign csr_addr_o   = entry_q.addr;

  // free when empty, or when the held entry leaves this cycle
  assign csr_ready_o = ~entry_q.valid | csr_commit_i;

  always_comb begin
    entry_n = entry_q;
    // new issue takes the slot, even while the old one commits
    if (csr_valid_i) begin
      entry_n.addr  = fu_data_i.operand_b[11:0];
      entry_n.valid = 1'b1;
    end else if (csr_commit_i) begin
      entry_n.valid = 1'b0;
    end
    if (flush_i) begin
      entry_n.valid = 1'b0;
    end
  end

  // reset empties the entry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      entry_q.valid <= 1'b0;
    end else begin
      entry_q <= entry_n;
    end
  end

endmodule

`default_nettype wire

// File: source/csr_instr_queue.sv
// Circular FIFO of CSR instructions.
// A push while full or a pop while empty is ignored. Flush drops all
// entries and wins over a push in the same cycle. The head is valid
// only while empty_o is low.
`default_nettype none

`include "csr_unit_settings.svh"

module csr_instr_queue
  import csr_unit_pkg::*;
#(
  parameter int unsigned DEPTH = `QUEUE_DEPTH
) (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        flush_i,
  input  wire logic        push_i,
  input  wire csr_instr_t  data_i,
  input  wire logic        pop_i,
  output      csr_instr_t  data_o,
  output      logic        empty_o,
  output      logic        full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  csr_instr_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == FULL_CNT);
  assign data_o  = mem_q[rd_ptr_q];

  // qualified strobes
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage, no reset
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/csr_commit.sv
// Issue and commit control for the CSR path.
// Issues the queue head when the buffer is ready, then commits it in the
// next cycle. Issue and commit overlap, so one instruction per cycle can
// flow. Flush cancels a commit in the same cycle and blocks issue.
// Results have no back-pressure.
`default_nettype none

`include "csr_unit_settings.svh"

module csr_commit
  import csr_unit_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              flush_i,
  input  wire csr_instr_t        head_i,
  input  wire logic              empty_i,
  output      logic              pop_o,
  output      fu_data_t          fu_data_o,
  output      logic              csr_valid_o,
  input  wire logic              csr_ready_i,
  input  wire logic [`XLEN-1:0]  csr_operand_i,
  output      logic              csr_commit_o,
  output      logic              rf_we_o,
  output      csr_op_e           rf_op_o,
  output      logic [`XLEN-1:0]  rf_wdata_o,
  input  wire csr_result_t       rf_result_i,
  output      logic              result_valid_o,
  output      csr_result_t       result_o
);

  // op and operand waiting for their commit cycle
  typedef struct packed {
    csr_op_e           op;
    logic [`XLEN-1:0]  operand;
    logic              valid;
  } pend_t;

  pend_t       pend_q;
  pend_t       pend_n;
  logic        issue;
  logic        result_valid_q;
  csr_result_t result_q;

  assign issue = ~empty_i & csr_ready_i & ~flush_i;

  assign pop_o       = issue;
  assign csr_valid_o = issue;

  // address travels in operand_b, zero extended
  assign fu_data_o.op        = head_i.op;
  assign fu_data_o.operand_a = head_i.operand;
  assign fu_data_o.operand_b = {{(`XLEN - 12){1'b0}}, head_i.addr};

  // commit always follows issue by exactly one cycle
  assign csr_commit_o = pend_q.valid & ~flush_i;
  assign rf_we_o      = csr_commit_o;
  assign rf_op_o      = pend_q.op;
  assign rf_wdata_o   = pend_q.operand;

  always_comb begin
    pend_n = pend_q;
    if (csr_commit_o) begin
      pend_n.valid = 1'b0;
    end
    // operand comes back through the buffer
    if (issue) begin
      pend_n.op      = fu_data_o.op;
      pend_n.operand = csr_operand_i;
      pend_n.valid   = 1'b1;
    end
    if (flush_i) begin
      pend_n.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q.valid   <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      pend_q         <= pend_n;
      result_valid_q <= csr_commit_o;
    end
  end

  // old value captured in the commit cycle
  always_ff @(posedge clk_i) begin
    if (csr_commit_o) begin
      result_q <= rf_result_i;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire

// File: csr_regfile/csr_regfile.sv
// Small CSR register file with read-modify-write.
// Only CSR_COUNT registers exist, from CSR_BASE upward. Any other address
// reads as zero with illegal set and is never written. The old value is
// returned combinationally and the new value lands at the clock edge.
// CSR_COUNT must fit in the 12-bit address space above CSR_BASE.
`default_nettype none

`include "csr_unit_settings.svh"

module csr_regfile
  import csr_unit_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              we_i,
  input  wire logic [11:0]       addr_i,
  input  wire csr_op_e           op_i,
  input  wire logic [`XLEN-1:0]  wdata_i,
  output      csr_result_t       result_o
);

  localparam int unsigned IDX_W = (`CSR_COUNT > 1) ? $clog2(`CSR_COUNT) : 1;
  localparam logic [11:0] COUNT_12 = 12'(`CSR_COUNT);

  logic [`XLEN-1:0] csr_q [`CSR_COUNT];
  logic [11:0]      offset;
  logic [IDX_W-1:0] idx;
  logic             legal;
  logic [`XLEN-1:0] old_value;
  logic [`XLEN-1:0] new_value;

  // offset into the window; addresses below base wrap high
  // and fail the range check as well
  assign offset = addr_i - `CSR_BASE;
  assign legal  = (offset < COUNT_12);
  assign idx    = offset[IDX_W-1:0];

  // out-of-window reads never reach the array output
  assign old_value = legal ? csr_q[idx] : '0;

  assign result_o.rdata   = old_value;
  assign result_o.illegal = ~legal;

  // modify step
  always_comb begin
    new_value = old_value;
    case (op_i)
      CSR_WRITE: begin
        new_value = wdata_i;
      end
      CSR_SET: begin
        new_value = old_value | wdata_i;
      end
      CSR_CLEAR: begin
        new_value = old_value & ~wdata_i;
      end
      default: begin
        // read keeps the value
        new_value = old_value;
      end
    endcase
  end

  // all csrs start at zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CSR_COUNT; i++) begin
        csr_q[i] <= '0;
      end
    end else if (we_i && legal) begin
      csr_q[idx] <= new_value;
    end
  end

endmodule

`default_nettype wire

// File: source/csr_subsystem.sv
// Top level of the CSR execution path.
// Inputs are accepted while full_o is low; an instruction offered
// while full_o is high is dropped. One result strobe per accepted
// instruction, in acceptance order, except those discarded by flush_i.
`default_nettype none

`include "csr_unit_settings.svh"

module csr_subsystem
  import csr_unit_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        flush_i,
  input  wire logic        instr_valid_i,
  input  wire csr_instr_t  instr_i,
  output      logic        full_o,
  output      logic        result_valid_o,
  output      csr_result_t result_o
);

  csr_instr_t        queue_head;
  logic              queue_empty;
  logic              queue_pop;
  fu_data_t          fu_data;
  logic              csr_valid;
  logic              csr_ready;
  logic [`XLEN-1:0]  csr_operand;
  logic              csr_commit;
  logic [11:0]       csr_addr;
  logic              rf_we;
  csr_op_e           rf_op;
  logic [`XLEN-1:0]  rf_wdata;
  csr_result_t       rf_result;

  // instruction queue
  csr_instr_queue #(
    .DEPTH   (`QUEUE_DEPTH)
  ) u_csr_instr_queue (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .push_i  (instr_valid_i),
    .data_i  (instr_i),
    .pop_i   (queue_pop),
    .data_o  (queue_head),
    .empty_o (queue_empty),
    .full_o  (full_o)
  );

  // address holding buffer
  csr_buffer u_csr_buffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .fu_data_i    (fu_data),
    .csr_valid_i  (csr_valid),
    .csr_ready_o  (csr_ready),
    .csr_result_o (csr_operand),
    .csr_commit_i (csr_commit),
    .csr_addr_o   (csr_addr)
  );

  // issue, pending slot and result register
  csr_commit u_csr_commit (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .head_i         (queue_head),
    .empty_i        (queue_empty),
    .pop_o          (queue_pop),
    .fu_data_o      (fu_data),
    .csr_valid_o    (csr_valid),
    .csr_ready_i    (csr_ready),
    .csr_operand_i  (csr_operand),
    .csr_commit_o   (csr_commit),
    .rf_we_o        (rf_we),
    .rf_op_o        (rf_op),
    .rf_wdata_o     (rf_wdata),
    .rf_result_i    (rf_result),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  // csr storage, addressed from the buffer
  csr_regfile u_csr_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .we_i     (rf_we),
    .addr_i   (csr_addr),
    .op_i     (rf_op),
    .wdata_i  (rf_wdata),
    .result_o (rf_result)
  );

endmodule

`default_nettype wire

// File: testbench/tb_csr_subsystem.sv
// Random-stimulus testbench for the CSR execution path.
// A model applies each instruction when its result arrives, so a flush
// only removes instructions that never answered. Inputs change on the
// rising edge and outputs are sampled on the falling edge.
// The run is bounded by a cycle limit derived from the instruction count.
`default_nettype none

`include "csr_unit_settings.svh"

module tb_csr_subsystem
  import csr_unit_pkg::*;
();

  localparam int unsigned SEED        = 29306;
  localparam int          IDX_W       = (`CSR_COUNT > 1) ? $clog2(`CSR_COUNT) : 1;
  localparam int          NUM_ILLEGAL = 8;
  localparam int          DEP_LEN     = 16;
  localparam int          BURST_LEN   = 12;
  localparam int          NUM_RANDOM  = 200;
  localparam int          FLUSH_BURST = 6;
  localparam int          NUM_INSTR   = 3 * `CSR_COUNT + `CSR_COUNT * 6 + NUM_ILLEGAL
                                        + DEP_LEN + BURST_LEN + NUM_RANDOM + FLUSH_BURST;
  // four cycles per instruction covers idle gaps; the margin covers reset and drains
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 4 + 200;

  logic        clk;
  logic        rst;
  logic        flush;
  logic        instr_valid;
  csr_instr_t  instr;
  logic        full;
  logic        result_valid;
  csr_result_t result;

  // model state
  logic [`XLEN-1:0] model_csr [`CSR_COUNT];
  csr_instr_t       pend_q [$];
  csr_instr_t       mon_instr;
  csr_result_t      mon_exp;
  int               q_level;
  int               error_count;
  int               result_count;
  int               cycle_count;

  csr_subsystem u_csr_subsystem (
    .clk_i          (clk),
    .rst_i          (rst),
    .flush_i        (flush),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .full_o         (full),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic in_window(input logic [11:0] addr);
    int base;
    base = int'(`CSR_BASE);
    return (int'(addr) >= base) && (int'(addr) < base + `CSR_COUNT);
  endfunction

  // old value out, new value into the model array
  task automatic model_commit(input csr_instr_t ins, output csr_result_t exp);
    logic [IDX_W-1:0] idx;
    logic [`XLEN-1:0] old_value;
    exp = '0;
    if (!in_window(ins.addr)) begin
      // zero data, nothing written
      exp.illegal = 1'b1;
    end else begin
      idx = IDX_W'(int'(ins.addr) - int'(`CSR_BASE));
      old_value = model_csr[idx];
      exp.rdata = old_value;
      case (ins.op)
        CSR_WRITE: model_csr[idx] = ins.operand;
        CSR_SET:   model_csr[idx] = old_value | ins.operand;
        CSR_CLEAR: model_csr[idx] = old_value & ~ins.operand;
        default: begin
        end
      endcase
    end
  endtask

  function automatic csr_instr_t make_instr(input csr_op_e op, input logic [11:0] addr,
                                            input logic [`XLEN-1:0] operand);
    csr_instr_t ins;
    ins.op = op;
    ins.addr = addr;
    ins.operand = operand;
    return ins;
  endfunction

  function automatic logic [11:0] csr_addr_of(input int idx);
    return 12'(int'(`CSR_BASE) + idx);
  endfunction

  function automatic logic [`XLEN-1:0] rand_data();
    return `XLEN'($urandom);
  endfunction

  function automatic csr_op_e rand_op();
    return csr_op_e'(2'($urandom_range(3)));
  endfunction

  function automatic logic [11:0] rand_legal_addr();
    return csr_addr_of(int'($urandom_range(`CSR_COUNT - 1)));
  endfunction

  function automatic logic [11:0] rand_illegal_addr();
    logic [11:0] addr;
    addr = 12'($urandom);
    while (in_window(addr)) begin
      addr = 12'($urandom);
    end
    return addr;
  endfunction

  // about one in eight outside the window
  function automatic csr_instr_t rand_instr();
    logic [11:0] addr;
    if ($urandom_range(7) == 0) begin
      addr = rand_illegal_addr();
    end else begin
      addr = rand_legal_addr();
    end
    return make_instr(rand_op(), addr, rand_data());
  endfunction

  // offer on the rising edge, record once full_o is seen low
  task automatic send_instr(input csr_instr_t ins);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= ins;
    @(negedge clk);
    while (full) begin
      @(negedge clk);
    end
    pend_q.push_back(ins);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    while (pend_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < `CSR_COUNT; i++) begin
      send_instr(make_instr(CSR_READ, csr_addr_of(i), rand_data()));
    end
  endtask

  // one-cycle flush right after the last offer
  task automatic flush_pipeline(output int n_dropped);
    @(posedge clk);
    instr_valid <= 1'b0;
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    // results of commits before the flush were taken at the last falling edge
    n_dropped = pend_q.size();
    pend_q.delete();
  endtask

  // results leave in acceptance order
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (pend_q.size() == 0) begin
        error_count++;
        $display("result strobe at time %0t with no instruction outstanding", $time);
      end else begin
        mon_instr = pend_q.pop_front();
        model_commit(mon_instr, mon_exp);
        check_value(result.rdata, mon_exp.rdata, "rdata");
        check_value(`XLEN'(result.illegal), `XLEN'(mon_exp.illegal), "illegal flag");
        result_count++;
      end
    end
  end

  // expected queue level: one entry in per accepted offer, one out per
  // cycle while it holds anything, as the buffer is freed by every commit
  always @(negedge clk) begin
    if (!rst) begin
      check_value(`XLEN'(full), `XLEN'(q_level >= `QUEUE_DEPTH), "full_o");
    end
    if (rst || flush) begin
      q_level = 0;
    end else begin
      if (q_level > 0) begin
        q_level = q_level - 1;
      end
      if (instr_valid && q_level < `QUEUE_DEPTH) begin
        q_level = q_level + 1;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, results stopped arriving (%0d outstanding)",
             cycle_count, pend_q.size());
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [11:0] addr;
    int          n_dropped;
    void'($urandom(SEED));
    rst = 1'b1;
    flush = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    q_level = 0;
    error_count = 0;
    result_count = 0;
    model_csr = '{default: '0};
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // quiet after reset, then every csr reads zero
    idle_cycles(4);
    read_all();

    // each op on each csr, read back after each
    for (int i = 0; i < `CSR_COUNT; i++) begin
      addr = csr_addr_of(i);
      send_instr(make_instr(CSR_WRITE, addr, rand_data()));
      send_instr(make_instr(CSR_READ, addr, rand_data()));
      send_instr(make_instr(CSR_SET, addr, rand_data()));
      send_instr(make_instr(CSR_READ, addr, rand_data()));
      send_instr(make_instr(CSR_CLEAR, addr, rand_data()));
      send_instr(make_instr(CSR_READ, addr, rand_data()));
    end

    // out-of-window addresses, then confirm nothing moved
    for (int i = 0; i < NUM_ILLEGAL; i++) begin
      send_instr(make_instr(rand_op(), rand_illegal_addr(), rand_data()));
    end
    read_all();

    // dependent chain on one csr, issue overlaps commit
    addr = rand_legal_addr();
    for (int i = 0; i < DEP_LEN; i++) begin
      send_instr(make_instr(rand_op(), addr, rand_data()));
    end

    // burst longer than the queue
    for (int i = 0; i < BURST_LEN; i++) begin
      send_instr(rand_instr());
    end

    // random traffic with short idle gaps
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycles(1 + int'($urandom_range(1)));
      end
      send_instr(rand_instr());
    end

    // flush with a burst in flight, checked by the reads after it
    wait_drain();
    for (int i = 0; i < FLUSH_BURST; i++) begin
      send_instr(make_instr(rand_op(), rand_legal_addr(), rand_data()));
    end
    flush_pipeline(n_dropped);
    if (n_dropped == 0) begin
      error_count++;
      $display("flush at time %0t discarded no instruction of the burst", $time);
    end
    idle_cycles(4);
    read_all();

    // the last read answers two cycles after it is taken
    idle_cycles(6);
    if (pend_q.size() != 0) begin
      error_count++;
      $display("%0d accepted instructions never produced a result", pend_q.size());
    end
    $display("errors: %0d, results checked: %0d", error_count, result_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_subsystem.f
+incdir+common
common/csr_unit_pkg.sv
source/csr_buffer.sv
source/csr_instr_queue.sv
source/csr_commit.sv
csr_regfile/csr_regfile.sv
source/csr_subsystem.sv
testbench/tb_csr_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_csr_subsystem
FILELIST  := csr_subsystem.f
BUILD_DIR := obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
